//--- verilog/common_defs.svh
`ifndef COMMON_DEFS_SVH
`define COMMON_DEFS_SVH

// bus geometry
`define ADDRESS_WIDTH 32
`define DATA_WIDTH    32
`define MASK_WIDTH    4

// top address bits pick the region
`define PREFIX_WIDTH  4

`define RAM_PREFIX    4'h0
`define UART_PREFIX   4'h8
`define TIMER_PREFIX  4'h9
`define GPIO_PREFIX   4'ha

// word address bits per slave, starting at address bit 2
`define RAM_ADDRESS_WIDTH   8
`define UART_ADDRESS_WIDTH  1
`define TIMER_ADDRESS_WIDTH 2
`define GPIO_ADDRESS_WIDTH  1

// register offsets (word index)
`define UART_REG_DATA     1'b0 // write side
`define UART_REG_STATUS   1'b0 // read side
`define TIMER_REG_CTRL    2'd0
`define TIMER_REG_COUNT   2'd1
`define TIMER_REG_COMPARE 2'd2
`define GPIO_REG_OUT      1'b0
`define GPIO_REG_IN       1'b1

// clocks per uart bit
`define UART_DIVISOR 4

`define ZERO_WORD {`DATA_WIDTH{1'b0}}
`define ZERO_BIT  1'b0

`endif

//--- verilog/bus_pkg.sv
`default_nettype none

`include "common_defs.svh"

package bus_pkg;

    // request from the core
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`ADDRESS_WIDTH-1:0] address;
        logic [`DATA_WIDTH-1:0]    data_wr;
        logic [`MASK_WIDTH-1:0]    mask;
    } bus_req_t;

    // per-slave request, address is already a word index
    typedef struct packed {
        logic                          read;
        logic                          write;
        logic [`RAM_ADDRESS_WIDTH-1:0] address; // widest slave, others use low bits
        logic [`DATA_WIDTH-1:0]        data_wr;
        logic [`MASK_WIDTH-1:0]        mask;
    } slave_req_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data_rd;
        logic                   stall;
        logic                   interrupt;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_UART,
        REGION_TIMER,
        REGION_GPIO,
        REGION_NONE
    } region_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

`default_nettype wire

//--- verilog/data_bus.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module data_bus import bus_pkg::*; (
    input  wire bus_req_t cpu_req,
    output bus_rsp_t      cpu_rsp,
    output slave_req_t    ram_req,
    output slave_req_t    uart_req,
    output slave_req_t    timer_req,
    output slave_req_t    gpio_req,
    input  wire bus_rsp_t ram_rsp,
    input  wire bus_rsp_t uart_rsp,
    input  wire bus_rsp_t timer_rsp,
    input  wire bus_rsp_t gpio_rsp
);

    region_t    region;
    slave_req_t common; // broadcast fields, read/write cleared

    always_comb begin
        unique case (cpu_req.address[`ADDRESS_WIDTH-1 -: `PREFIX_WIDTH])
            `RAM_PREFIX:   region = REGION_RAM;
            `UART_PREFIX:  region = REGION_UART;
            `TIMER_PREFIX: region = REGION_TIMER;
            `GPIO_PREFIX:  region = REGION_GPIO;
            default:       region = REGION_NONE; // old flash/gfx/eth/usb slots and holes
        endcase
    end

    always_comb begin
        common.read    = `ZERO_BIT;
        common.write   = `ZERO_BIT;
        common.address = cpu_req.address[2 +: `RAM_ADDRESS_WIDTH];
        common.data_wr = cpu_req.data_wr;
        common.mask    = cpu_req.mask;
    end

    always_comb begin
        ram_req   = common;
        uart_req  = common;
        timer_req = common;
        gpio_req  = common;

        cpu_rsp.data_rd   = `ZERO_WORD;
        cpu_rsp.stall     = `ZERO_BIT;
        cpu_rsp.interrupt = uart_rsp.interrupt | timer_rsp.interrupt;

        case (region)
            REGION_RAM: begin
                ram_req.read    = cpu_req.read;
                ram_req.write   = cpu_req.write;
                cpu_rsp.data_rd = ram_rsp.data_rd;
                cpu_rsp.stall   = ram_rsp.stall;
            end
            REGION_UART: begin
                uart_req.read   = cpu_req.read;
                uart_req.write  = cpu_req.write;
                cpu_rsp.data_rd = uart_rsp.data_rd;
                cpu_rsp.stall   = uart_rsp.stall; // back-pressure on busy tx
            end
            REGION_TIMER: begin
                timer_req.read  = cpu_req.read;
                timer_req.write = cpu_req.write;
                cpu_rsp.data_rd = timer_rsp.data_rd;
                cpu_rsp.stall   = timer_rsp.stall;
            end
            REGION_GPIO: begin
                gpio_req.read   = cpu_req.read;
                gpio_req.write  = cpu_req.write;
                cpu_rsp.data_rd = gpio_rsp.data_rd;
                cpu_rsp.stall   = gpio_rsp.stall;
            end
            default: ; // unmapped reads as zero, never stalls
        endcase

        // only one slave may own the access
        assert ($onehot0({ram_req.read | ram_req.write, uart_req.read | uart_req.write,
                          timer_req.read | timer_req.write, gpio_req.read | gpio_req.write}))
            else $error("data_bus: more than one slave selected");
    end

endmodule

`default_nettype wire

//--- verilog/sram_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module sram_ctrl import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire slave_req_t req,
    output bus_rsp_t        rsp
);

    localparam int DEPTH = 1 << `RAM_ADDRESS_WIDTH;

    logic [`DATA_WIDTH-1:0]        mem [0:DEPTH-1];
    logic [`DATA_WIDTH-1:0]        rd_data;
    logic [`RAM_ADDRESS_WIDTH-1:0] addr;
    logic                          pending; // second cycle of a read

    assign addr = req.address;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= `ZERO_BIT;
        end else if (req.read) begin
            pending <= !pending; // set on first cycle, cleared on completion
        end else begin
            pending <= `ZERO_BIT;
        end
    end

    always_ff @(posedge clk) begin
        if (req.write) begin
            for (int i = 0; i < `MASK_WIDTH; i++) begin
                if (req.mask[i])
                    mem[addr][8*i +: 8] <= req.data_wr[8*i +: 8];
            end
        end
        if (req.read && !pending)
            rd_data <= mem[addr];
    end

    assign rsp.data_rd   = rd_data;
    assign rsp.stall     = req.read && !pending;
    assign rsp.interrupt = `ZERO_BIT;

    // the core keeps read and address steady through the stall cycle
    property p_one_stall;
        @(posedge clk) disable iff (!rst_n)
            rsp.stall |=> (req.read && $stable(req.address));
    endproperty
    a_one_stall: assert property (p_one_stall)
        else $error("sram_ctrl: read dropped or address changed while stalled");

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module uart_tx import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire slave_req_t req,
    output bus_rsp_t        rsp,
    output logic            txd
);

    localparam int DIV_W = $clog2(`UART_DIVISOR);

    uart_state_t state;
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             done;
    logic             busy;
    logic             data_wr_sel;
    logic             status_rd_sel;
    logic             bit_end;

    assign busy          = (state != UART_IDLE);
    assign data_wr_sel   = req.write && (req.address[`UART_ADDRESS_WIDTH-1:0] == `UART_REG_DATA);
    assign status_rd_sel = req.read && (req.address[`UART_ADDRESS_WIDTH-1:0] == `UART_REG_STATUS);
    assign bit_end       = (div_cnt == DIV_W'(`UART_DIVISOR - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= UART_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            txd     <= 1'b1;
            done    <= `ZERO_BIT;
        end else begin
            if (status_rd_sel)
                done <= `ZERO_BIT; // read clears
            div_cnt <= busy ? div_cnt + 1'b1 : '0;
            case (state)
                UART_IDLE: if (data_wr_sel) begin
                    shift_reg <= req.data_wr[7:0];
                    txd       <= 1'b0; // start bit
                    state     <= UART_START;
                end
                UART_START: if (bit_end) begin
                    txd       <= shift_reg[0];
                    shift_reg <= shift_reg >> 1;
                    bit_cnt   <= '0;
                    state     <= UART_DATA;
                end
                UART_DATA: if (bit_end) begin
                    if (bit_cnt == 3'd7) begin
                        txd   <= 1'b1; // stop bit
                        state <= UART_STOP;
                    end else begin
                        txd       <= shift_reg[0];
                        shift_reg <= shift_reg >> 1;
                        bit_cnt   <= bit_cnt + 1'b1;
                    end
                end
                UART_STOP: if (bit_end) begin
                    done  <= 1'b1;
                    state <= UART_IDLE;
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    assign rsp.data_rd   = status_rd_sel ? {{(`DATA_WIDTH-2){1'b0}}, done, busy} : `ZERO_WORD;
    assign rsp.stall     = data_wr_sel && busy;
    assign rsp.interrupt = done;

    a_idle_line: assert property (@(posedge clk) disable iff (!rst_n) (state == UART_IDLE) |-> txd)
        else $error("uart_tx: line low while idle");

endmodule

`default_nettype wire

//--- verilog/timer_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module timer_unit import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire slave_req_t req,
    output bus_rsp_t        rsp
);

    logic                           enable;
    logic                           pending; // sticky compare match
    logic [`DATA_WIDTH-1:0]         count;
    logic [`DATA_WIDTH-1:0]         compare;
    logic [`TIMER_ADDRESS_WIDTH-1:0] reg_sel;

    assign reg_sel = req.address[`TIMER_ADDRESS_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable  <= `ZERO_BIT;
            pending <= `ZERO_BIT;
            count   <= `ZERO_WORD;
            compare <= `ZERO_WORD;
        end else begin
            if (enable)
                count <= count + 1'b1;
            if (req.write) begin
                case (reg_sel)
                    `TIMER_REG_CTRL: begin
                        enable <= req.data_wr[0];
                        if (req.data_wr[1])
                            pending <= `ZERO_BIT; // write one to clear
                    end
                    `TIMER_REG_COUNT:   count   <= req.data_wr;
                    `TIMER_REG_COMPARE: compare <= req.data_wr;
                    default: ;
                endcase
            end
            if (enable && count == compare)
                pending <= 1'b1; // match wins over a clear
        end
    end

    always_comb begin
        rsp.data_rd = `ZERO_WORD;
        if (req.read) begin
            case (reg_sel)
                `TIMER_REG_CTRL:    rsp.data_rd = {{(`DATA_WIDTH-2){1'b0}}, pending, enable};
                `TIMER_REG_COUNT:   rsp.data_rd = count;
                `TIMER_REG_COMPARE: rsp.data_rd = compare;
                default: ;
            endcase
        end
        rsp.stall     = `ZERO_BIT;
        rsp.interrupt = pending;
    end

endmodule

`default_nettype wire

//--- verilog/gpio_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module gpio_port import bus_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire slave_req_t        req,
    output bus_rsp_t               rsp,
    input  wire [`DATA_WIDTH-1:0]  gpio_in,
    output logic [`DATA_WIDTH-1:0] gpio_out
);

    logic [`DATA_WIDTH-1:0]         in_meta;
    logic [`DATA_WIDTH-1:0]         in_sync;
    logic [`GPIO_ADDRESS_WIDTH-1:0] reg_sel;

    assign reg_sel = req.address[`GPIO_ADDRESS_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= `ZERO_WORD;
        end else if (req.write && reg_sel == `GPIO_REG_OUT) begin
            for (int i = 0; i < `MASK_WIDTH; i++) begin
                if (req.mask[i])
                    gpio_out[8*i +: 8] <= req.data_wr[8*i +: 8];
            end
        end
    end

    // two-flop synchronizer on the pins
    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    assign rsp.data_rd   = (reg_sel == `GPIO_REG_IN) ? in_sync : gpio_out;
    assign rsp.stall     = `ZERO_BIT;
    assign rsp.interrupt = `ZERO_BIT;

endmodule

`default_nettype wire

//--- verilog/soc_bus_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module soc_bus_top import bus_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire bus_req_t          cpu_req,
    output bus_rsp_t               cpu_rsp,
    input  wire [`DATA_WIDTH-1:0]  gpio_in,
    output logic [`DATA_WIDTH-1:0] gpio_out,
    output logic                   uart_txd
);

    slave_req_t ram_req;
    slave_req_t uart_req;
    slave_req_t timer_req;
    slave_req_t gpio_req;
    bus_rsp_t   ram_rsp;
    bus_rsp_t   uart_rsp;
    bus_rsp_t   timer_rsp;
    bus_rsp_t   gpio_rsp;

    data_bus i_data_bus (
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .ram_req   (ram_req),
        .uart_req  (uart_req),
        .timer_req (timer_req),
        .gpio_req  (gpio_req),
        .ram_rsp   (ram_rsp),
        .uart_rsp  (uart_rsp),
        .timer_rsp (timer_rsp),
        .gpio_rsp  (gpio_rsp)
    );

    sram_ctrl i_sram_ctrl (.clk(clk), .rst_n(rst_n), .req(ram_req), .rsp(ram_rsp));

    uart_tx i_uart_tx (.clk(clk), .rst_n(rst_n), .req(uart_req), .rsp(uart_rsp), .txd(uart_txd));

    timer_unit i_timer_unit (.clk(clk), .rst_n(rst_n), .req(timer_req), .rsp(timer_rsp));

    gpio_port i_gpio_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (gpio_req),
        .rsp      (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

`default_nettype wire

//--- tests/tb_soc_bus.sv
`timescale 1ns/100ps
`default_nettype none

`include "common_defs.svh"

module tb_soc_bus import bus_pkg::*; ();

    localparam int CLK_PERIOD      = 4;
    localparam int RAM_OPS         = 300;
    localparam int FRAME_CYCLES    = 10 * `UART_DIVISOR;
    localparam int TIMER_COMPARE   = 20;
    localparam int WATCHDOG_CYCLES = RAM_OPS * 4 + 4 * 50 + 500;

    logic                   clk;
    logic                   rst_n;
    bus_req_t               cpu_req;
    bus_rsp_t               cpu_rsp;
    logic [`DATA_WIDTH-1:0] gpio_in;
    logic [`DATA_WIDTH-1:0] gpio_out;
    logic                   uart_txd;

    logic [`DATA_WIDTH-1:0] gpio_model;
    logic [`DATA_WIDTH-1:0] ram_model [0:(1 << `RAM_ADDRESS_WIDTH)-1];
    bit                     ram_written [0:(1 << `RAM_ADDRESS_WIDTH)-1];
    region_t                region;

    soc_bus_top i_soc_bus_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .uart_txd (uart_txd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic region_t region_of(input logic [`ADDRESS_WIDTH-1:0] addr);
        case (addr[`ADDRESS_WIDTH-1 -: `PREFIX_WIDTH])
            `RAM_PREFIX:   return REGION_RAM;
            `UART_PREFIX:  return REGION_UART;
            `TIMER_PREFIX: return REGION_TIMER;
            `GPIO_PREFIX:  return REGION_GPIO;
            default:       return REGION_NONE;
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < `MASK_WIDTH; i++) begin
            if (mask[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] make_address(input logic [3:0] prefix, input int word);
        return {prefix, 28'(word * 4)};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        $display("Regression failed");
        $fatal(1);
    endtask

    // holds the request until an edge without stall, data is taken mid-cycle
    task automatic finish_transfer(output logic [31:0] data, output int stalls);
        stalls = 0;
        @(negedge clk);
        while (cpu_rsp.stall) begin
            stalls++;
            @(negedge clk);
        end
        data = cpu_rsp.data_rd;
        @(posedge clk);
        #1;
        cpu_req = '0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask, output int stalls);
        logic [31:0] unused;
        cpu_req = '{read: 1'b0, write: 1'b1, address: addr, data_wr: data, mask: mask};
        finish_transfer(unused, stalls);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output int stalls);
        cpu_req = '{read: 1'b1, write: 1'b0, address: addr, data_wr: `ZERO_WORD, mask: 4'h0};
        finish_transfer(data, stalls);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] expected,
                               input int exp_stalls, input string name);
        logic [31:0] data;
        int          stalls;
        bus_read(addr, data, stalls);
        assert (data == expected) else report_mismatch(name, expected, data);
        assert (stalls == exp_stalls) else report_mismatch({name, " stalls"}, exp_stalls, stalls);
    endtask

    task automatic check_idle_outputs();
        assert (!cpu_rsp.stall) else report_mismatch("cpu_rsp.stall", 0, cpu_rsp.stall);
        assert (!cpu_rsp.interrupt) else report_mismatch("cpu_rsp.interrupt", 0, 1);
        assert (uart_txd) else report_mismatch("uart_txd", 1, uart_txd);
        assert (gpio_out == `ZERO_WORD) else report_mismatch("gpio_out", `ZERO_WORD, gpio_out);
    endtask

    task automatic test_gpio_unmapped();
        logic [31:0] data;
        logic [3:0]  mask;
        int          stalls;
        for (int n = 0; n < 4; n++) begin
            data = $urandom;
            mask = 4'($urandom);
            bus_write(make_address(`GPIO_PREFIX, 0), data, mask, stalls);
            gpio_model = merge_bytes(gpio_model, data, mask);
            read_expect(make_address(`GPIO_PREFIX, 0), gpio_model, 0, "gpio output register");
        end
        data = $urandom;
        gpio_in = data;
        repeat (2) @(posedge clk); // through both sync flops
        #1;
        read_expect(make_address(`GPIO_PREFIX, 1), data, 0, "gpio input register");
        for (int p = 1; p < 16; p++) begin
            if (p < 8 || p > 10)
                read_expect(make_address(4'(p), $urandom % 1024), `ZERO_WORD, 0, "unmapped read");
        end
    endtask

    task automatic test_ram();
        int          idx;
        int          stalls;
        int          used [$];
        logic [31:0] data;
        logic [3:0]  mask;
        for (int n = 0; n < RAM_OPS; n++) begin
            if (used.size() != 0 && $urandom % 2 == 1) begin
                idx = used[$urandom % used.size()];
                read_expect(make_address(`RAM_PREFIX, idx), ram_model[idx], 1, "ram read data");
            end else begin
                idx = $urandom % (1 << `RAM_ADDRESS_WIDTH);
                data = $urandom;
                mask = ram_written[idx] ? 4'($urandom) : 4'hf; // first write fills the word
                bus_write(make_address(`RAM_PREFIX, idx), data, mask, stalls);
                assert (stalls == 0) else report_mismatch("ram write stalls", 0, stalls);
                if (!ram_written[idx])
                    used.push_back(idx);
                ram_written[idx] = 1'b1;
                ram_model[idx] = merge_bytes(ram_model[idx], data, mask);
            end
        end
    endtask

    task automatic test_timer();
        logic [31:0] first;
        logic [31:0] second;
        int          stalls;
        int          cycles;
        bus_write(make_address(`TIMER_PREFIX, 2), TIMER_COMPARE, 4'hf, stalls);
        bus_write(make_address(`TIMER_PREFIX, 1), `ZERO_WORD, 4'hf, stalls);
        read_expect(make_address(`TIMER_PREFIX, 2), TIMER_COMPARE, 0, "timer compare");
        bus_write(make_address(`TIMER_PREFIX, 0), 32'h1, 4'hf, stalls);
        cycles = 0;
        while (!cpu_rsp.interrupt && cycles <= TIMER_COMPARE + 2) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (cycles <= TIMER_COMPARE + 2)
            else report_mismatch("timer interrupt latency", TIMER_COMPARE + 2, cycles);
        bus_read(make_address(`TIMER_PREFIX, 1), first, stalls);
        bus_read(make_address(`TIMER_PREFIX, 1), second, stalls);
        assert (second > first) else report_mismatch("timer count", first + 1, second);
        bus_write(make_address(`TIMER_PREFIX, 0), 32'h2, 4'hf, stalls); // clear and stop
        assert (!cpu_rsp.interrupt) else report_mismatch("cpu_rsp.interrupt", 0, 1);
        read_expect(make_address(`TIMER_PREFIX, 0), `ZERO_WORD, 0, "timer control");
    endtask

    // samples the line in the middle of each bit, starting right after the accepting edge
    task automatic check_frame(input logic [7:0] value);
        logic expected;
        repeat (`UART_DIVISOR / 2 + 1) @(negedge clk);
        for (int k = 0; k < 10; k++) begin
            if (k > 0)
                repeat (`UART_DIVISOR) @(negedge clk);
            expected = (k == 0) ? 1'b0 : (k == 9) ? 1'b1 : value[k-1];
            assert (uart_txd == expected) else report_mismatch("uart_txd", expected, uart_txd);
        end
    endtask

    task automatic test_uart();
        logic [7:0] first;
        logic [7:0] second;
        int         stalls;
        first = 8'($urandom);
        second = 8'($urandom);
        bus_write(make_address(`UART_PREFIX, 0), {24'h0, first}, 4'h1, stalls);
        assert (stalls == 0) else report_mismatch("uart write stalls", 0, stalls);
        fork
            check_frame(first);
            begin
                bus_write(make_address(`UART_PREFIX, 0), {24'h0, second}, 4'h1, stalls);
                assert (stalls == FRAME_CYCLES)
                    else report_mismatch("uart busy write stalls", FRAME_CYCLES, stalls);
                check_frame(second);
            end
        join
        repeat (3) @(posedge clk); // past the end of the stop bit
        #1;
        assert (cpu_rsp.interrupt) else report_mismatch("cpu_rsp.interrupt", 1, 0);
        read_expect(make_address(`UART_PREFIX, 0), 32'h2, 0, "uart status");
        assert (!cpu_rsp.interrupt) else report_mismatch("cpu_rsp.interrupt", 0, 1);
        read_expect(make_address(`UART_PREFIX, 0), `ZERO_WORD, 0, "uart status after read");
    endtask

    always_comb region = region_of(cpu_req.address);

    a_unmapped_data: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.read && region == REGION_NONE) |-> cpu_rsp.data_rd == `ZERO_WORD)
        else report_mismatch("cpu_rsp.data_rd", `ZERO_WORD, $sampled(cpu_rsp.data_rd));

    a_unmapped_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.read && region == REGION_NONE) |-> !cpu_rsp.stall)
        else report_mismatch("cpu_rsp.stall", 0, 1);

    a_ram_write_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.write && region == REGION_RAM) |-> !cpu_rsp.stall)
        else report_mismatch("cpu_rsp.stall", 0, 1);

    a_ram_read_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.read && region == REGION_RAM && cpu_rsp.stall) |=> !cpu_rsp.stall)
        else report_mismatch("cpu_rsp.stall", 0, 1);

    a_gpio_out: assert property (@(posedge clk) disable iff (!rst_n) gpio_out == gpio_model)
        else report_mismatch("gpio_out", $sampled(gpio_model), $sampled(gpio_out));

    initial begin
        void'($urandom(32'h822d));
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_req = '0;
        gpio_in = `ZERO_WORD;
        gpio_model = `ZERO_WORD;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        repeat (6) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        #1;
        test_gpio_unmapped();
        test_ram();
        test_timer();
        test_uart();
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("Regression failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/data_bus.sv
verilog/sram_ctrl.sv
verilog/uart_tx.sv
verilog/timer_unit.sv
verilog/gpio_port.sv
verilog/soc_bus_top.sv
tests/tb_soc_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the soc bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    -f sim.f \
    --top-module tb_soc_bus \
    -Mdir obj_dir \
    -o tb_soc_bus
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/tb_soc_bus
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
